// ==== compile.f ====
design/pipePkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/pipeTop.sv
dv/clockGen.sv
dv/pipeMonitor.sv
dv/pipeTb.sv

// ==== design/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire pipePkg::ifIdT                        ifId,
    input  wire logic                                 redirect,
    input  wire logic                                 wbWrite,
    input  wire logic [pipePkg::regAddrWidth-1:0]     wbRd,
    input  wire logic [pipePkg::wordWidth-1:0]        wbData,
    output pipePkg::idExT                             idEx,
    output logic                                      stall
);

    localparam int immExt = pipePkg::wordWidth - 12;

    logic [pipePkg::wordWidth-1:0]    instr;
    logic [2:0]                       funct3;
    logic [pipePkg::regAddrWidth-1:0] rs1;
    logic [pipePkg::regAddrWidth-1:0] rs2;
    logic [pipePkg::regAddrWidth-1:0] rd;
    pipePkg::opcodeE                  opcode;
    pipePkg::ctrlT                    ctrl;
    logic [pipePkg::wordWidth-1:0]    imm;
    logic [pipePkg::wordWidth-1:0]    rs1Val;
    logic [pipePkg::wordWidth-1:0]    rs2Val;
    logic [pipePkg::wordWidth-1:0]    regs [2**pipePkg::regAddrWidth];
    logic                             usesRs1;
    logic                             checkRs2;

    assign instr  = ifId.instr;
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    ////////////////////////////////////////
    // control decode
    ////////////////////////////////////////

    always_comb begin
        case (instr[6:0])
            pipePkg::opLoad:   opcode = pipePkg::opLoad;
            pipePkg::opStore:  opcode = pipePkg::opStore;
            pipePkg::opBranch: opcode = pipePkg::opBranch;
            pipePkg::opImm:    opcode = pipePkg::opImm;
            pipePkg::opReg:    opcode = pipePkg::opReg;
            default:           opcode = pipePkg::opNone;
        endcase
    end

    always_comb begin
        ctrl = '0;
        case (opcode)
            pipePkg::opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memToReg  = 1'b1;
            end
            pipePkg::opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            pipePkg::opBranch: begin
                ctrl.branch   = (funct3[2:1] == 2'b00); // beq, bne only
                ctrl.branchNe = funct3[0];
            end
            pipePkg::opImm: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.regWrite  = (funct3 == 3'b000) || (funct3 == 3'b111);
                ctrl.aluOp     = (funct3 == 3'b111) ? pipePkg::aluAnd : pipePkg::aluAdd;
            end
            pipePkg::opReg: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = instr[30] ? pipePkg::aluSub : pipePkg::aluAdd;
                    3'b110:  ctrl.aluOp = pipePkg::aluOr;
                    3'b111:  ctrl.aluOp = pipePkg::aluAnd;
                    default: ctrl.regWrite = 1'b0; // unsupported, becomes a nop
                endcase
            end
            default: ctrl = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            pipePkg::opLoad,
            pipePkg::opImm:    imm = {{immExt{instr[31]}}, instr[31:20]};
            pipePkg::opStore:  imm = {{immExt{instr[31]}}, instr[31:25], instr[11:7]};
            pipePkg::opBranch: imm = {{(immExt-1){instr[31]}}, instr[31], instr[7],
                                      instr[30:25], instr[11:8], 1'b0};
            default:           imm = '0;
        endcase
    end

    ////////////////////////////////////////
    // register file
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (wbWrite && wbRd != '0) begin
            regs[wbRd] <= wbData;
        end
    end

    function automatic logic [pipePkg::wordWidth-1:0] readReg(
        input logic [pipePkg::regAddrWidth-1:0] idx
    );
        if (idx == '0) begin
            return '0;
        end
        if (wbWrite && wbRd == idx) begin
            return wbData; // write-through
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1Val = readReg(rs1);
        rs2Val = readReg(rs2);
    end

    // store data in rs2 is picked up from writeback by the memory stage
    assign usesRs1  = (opcode != pipePkg::opNone);
    assign checkRs2 = (opcode == pipePkg::opReg) || (opcode == pipePkg::opBranch);

    assign stall = idEx.ctrl.memRead && (idEx.rd != '0) &&
                   ((usesRs1 && idEx.rd == rs1) || (checkRs2 && idEx.rd == rs2));

    always_ff @(posedge clock) begin
        if (reset || stall || redirect) begin
            idEx <= '0;
        end else begin
            idEx.ctrl   <= ctrl;
            idEx.pc     <= ifId.pc;
            idEx.rs1Val <= rs1Val;
            idEx.rs2Val <= rs2Val;
            idEx.imm    <= imm;
            idEx.rs1    <= rs1;
            idEx.rs2    <= rs2;
            idEx.rd     <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== design/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire pipePkg::idExT                        idEx,
    input  wire pipePkg::exMemT                       exMemFb,
    input  wire logic                                 wbWrite,
    input  wire logic [pipePkg::regAddrWidth-1:0]     wbRd,
    input  wire logic [pipePkg::wordWidth-1:0]        wbData,
    output pipePkg::exMemT                            exMem,
    output logic                                      redirect,
    output logic [pipePkg::wordWidth-1:0]             target
);

    pipePkg::fwdSelE               fwdA;
    pipePkg::fwdSelE               fwdB;
    logic [pipePkg::wordWidth-1:0] opA;
    logic [pipePkg::wordWidth-1:0] opB;
    logic [pipePkg::wordWidth-1:0] aluB;
    logic [pipePkg::wordWidth-1:0] aluResult;

    ////////////////////////////////////////
    // forwarding
    ////////////////////////////////////////

    // a load in ex/mem has no data yet, only its address
    function automatic pipePkg::fwdSelE pickSource(
        input logic [pipePkg::regAddrWidth-1:0] rs
    );
        if (exMemFb.regWrite && !exMemFb.memRead && exMemFb.rd != '0 && exMemFb.rd == rs) begin
            return pipePkg::fwdMem;
        end
        if (wbWrite && wbRd != '0 && wbRd == rs) begin
            return pipePkg::fwdWb;
        end
        return pipePkg::fwdNone;
    endfunction

    function automatic logic [pipePkg::wordWidth-1:0] applyFwd(
        input pipePkg::fwdSelE               sel,
        input logic [pipePkg::wordWidth-1:0] regVal
    );
        case (sel)
            pipePkg::fwdMem: return exMemFb.aluResult;
            pipePkg::fwdWb:  return wbData;
            default:         return regVal;
        endcase
    endfunction

    always_comb begin
        fwdA = pickSource(idEx.rs1);
        fwdB = pickSource(idEx.rs2);
        opA  = applyFwd(fwdA, idEx.rs1Val);
        opB  = applyFwd(fwdB, idEx.rs2Val);
    end

    ////////////////////////////////////////
    // alu and branch
    ////////////////////////////////////////

    assign aluB = idEx.ctrl.aluSrcImm ? idEx.imm : opB;

    always_comb begin
        case (idEx.ctrl.aluOp)
            pipePkg::aluSub: aluResult = opA - aluB;
            pipePkg::aluAnd: aluResult = opA & aluB;
            pipePkg::aluOr:  aluResult = opA | aluB;
            default:         aluResult = opA + aluB;
        endcase
    end

    assign redirect = idEx.ctrl.branch && ((opA == opB) != idEx.ctrl.branchNe);
    assign target   = idEx.pc + idEx.imm;

    always_ff @(posedge clock) begin
        if (reset || redirect) begin
            exMem <= '0; // taken branch leaves a bubble
        end else begin
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.memRead   <= idEx.ctrl.memRead;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.aluResult <= aluResult;
            exMem.storeData <= opB;
            exMem.rs2       <= idEx.rs2;
            exMem.rd        <= idEx.rd;
        end
    end

endmodule

`default_nettype wire

// ==== design/fetchStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchStage #(
    parameter int imemWords = 64
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic                                 run,
    input  wire logic                                 progWrite,
    input  wire logic [$clog2(imemWords)-1:0]         progAddr,
    input  wire logic [pipePkg::wordWidth-1:0]        progData,
    input  wire logic                                 stall,
    input  wire logic                                 redirect,
    input  wire logic [pipePkg::wordWidth-1:0]        target,
    output pipePkg::ifIdT                             ifId
);

    localparam int imemAddrWidth = $clog2(imemWords);

    logic [pipePkg::wordWidth-1:0] imem [imemWords];
    logic [pipePkg::wordWidth-1:0] pc;
    logic [pipePkg::wordWidth-1:0] instr;

    always_ff @(posedge clock) begin
        if (progWrite && !run) begin // loader owns the memory while halted
            imem[progAddr] <= progData;
        end
    end

    assign instr = imem[pc[imemAddrWidth+1:2]]; // word index

    always_ff @(posedge clock) begin
        if (reset || !run) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    // flush wins over stall since the stalled slot is younger than the branch
    always_ff @(posedge clock) begin
        if (reset || !run || redirect) begin
            ifId <= '0; // instruction zero decodes as a bubble
        end else if (!stall) begin
            ifId.pc    <= pc;
            ifId.instr <= instr;
        end
    end

endmodule

`default_nettype wire

// ==== design/memoryStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memoryStage #(
    parameter int dmemWords = 64
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire pipePkg::exMemT                       exMem,
    input  wire pipePkg::memWbT                       memWbFb,
    output pipePkg::memWbT                            memWb,
    output logic                                      wbWrite,
    output logic [pipePkg::regAddrWidth-1:0]          wbRd,
    output logic [pipePkg::wordWidth-1:0]             wbData,
    output logic                                      storeValid,
    output logic [pipePkg::wordWidth-1:0]             storeAddr,
    output logic [pipePkg::wordWidth-1:0]             storeData
);

    localparam int dmemAddrWidth = $clog2(dmemWords);

    logic [pipePkg::wordWidth-1:0] dmem [dmemWords];
    logic [dmemAddrWidth-1:0]      index;
    logic                          storeFwd;
    logic [pipePkg::wordWidth-1:0] storeWord;
    logic [pipePkg::wordWidth-1:0] loadWord;

    assign index    = exMem.aluResult[dmemAddrWidth+1:2]; // byte address to word
    assign storeFwd = exMem.memWrite && memWbFb.regWrite && memWbFb.rd != '0 &&
                      memWbFb.rd == exMem.rs2;
    assign storeWord = storeFwd ? wbData : exMem.storeData;
    assign loadWord  = dmem[index];

    always_ff @(posedge clock) begin
        if (exMem.memWrite) begin
            dmem[index] <= storeWord;
        end
    end

    assign storeValid = exMem.memWrite;
    assign storeAddr  = exMem.aluResult;
    assign storeData  = storeWord;

    always_ff @(posedge clock) begin
        if (reset) begin
            memWb <= '0;
        end else begin
            memWb.regWrite  <= exMem.regWrite;
            memWb.memToReg  <= exMem.memRead;
            memWb.loadData  <= loadWord;
            memWb.aluResult <= exMem.aluResult;
            memWb.rd        <= exMem.rd;
        end
    end

    assign wbWrite = memWbFb.regWrite;
    assign wbRd    = memWbFb.rd;
    assign wbData  = memWbFb.memToReg ? memWbFb.loadData : memWbFb.aluResult;

endmodule

`default_nettype wire

// ==== design/pipePkg.sv ====
`default_nettype none

package pipePkg;

    localparam int wordWidth    = 32;
    localparam int regAddrWidth = 5;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    typedef enum logic [6:0] {
        opNone   = 7'b0000000,
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opBranch = 7'b1100011
    } opcodeE;

    typedef enum logic [1:0] {
        aluAdd = 2'd0,
        aluSub = 2'd1,
        aluAnd = 2'd2,
        aluOr  = 2'd3
    } aluOpE;

    typedef enum logic [1:0] {
        fwdNone = 2'd0, // register file value
        fwdMem  = 2'd1, // ex/mem result
        fwdWb   = 2'd2  // writeback value
    } fwdSelE;

    ////////////////////////////////////////
    // stage registers
    ////////////////////////////////////////

    typedef struct packed {
        logic  regWrite;
        logic  memRead;
        logic  memWrite;
        logic  branch;
        logic  branchNe;   // bne inverts the compare
        logic  aluSrcImm;
        logic  memToReg;
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        logic [wordWidth-1:0] pc;
        logic [wordWidth-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT                    ctrl;
        logic [wordWidth-1:0]    pc;
        logic [wordWidth-1:0]    rs1Val;
        logic [wordWidth-1:0]    rs2Val;
        logic [wordWidth-1:0]    imm;
        logic [regAddrWidth-1:0] rs1;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rd;
    } idExT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        logic [wordWidth-1:0]    aluResult;
        logic [wordWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rd;
    } exMemT;

    typedef struct packed {
        logic                    regWrite;
        logic                    memToReg;
        logic [wordWidth-1:0]    loadData;
        logic [wordWidth-1:0]    aluResult;
        logic [regAddrWidth-1:0] rd;
    } memWbT;

endpackage

`default_nettype wire

// ==== design/pipeTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeTop #(
    parameter int imemWords = 64,
    parameter int dmemWords = 64
) (
    input  wire logic                                 clock,
    input  wire logic                                 reset,
    input  wire logic                                 run,
    input  wire logic                                 progWrite,
    input  wire logic [$clog2(imemWords)-1:0]         progAddr,
    input  wire logic [pipePkg::wordWidth-1:0]        progData,
    output logic                                      storeValid,
    output logic [pipePkg::wordWidth-1:0]             storeAddr,
    output logic [pipePkg::wordWidth-1:0]             storeData
);

    pipePkg::ifIdT                    ifId;
    pipePkg::idExT                    idEx;
    pipePkg::exMemT                   exMem;
    pipePkg::memWbT                   memWb;
    logic                             stall;
    logic                             redirect;
    logic [pipePkg::wordWidth-1:0]    target;
    logic                             wbWrite;
    logic [pipePkg::regAddrWidth-1:0] wbRd;
    logic [pipePkg::wordWidth-1:0]    wbData;

    ////////////////////////////////////////
    // input side
    ////////////////////////////////////////

    fetchStage #(
        .imemWords (imemWords)
    ) fetchStage_inst (
        .clock     (clock),
        .reset     (reset),
        .run       (run),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .ifId      (ifId)
    );

    ////////////////////////////////////////
    // processing
    ////////////////////////////////////////

    decodeStage decodeStage_inst (
        .clock    (clock),
        .reset    (reset),
        .ifId     (ifId),
        .redirect (redirect),
        .wbWrite  (wbWrite),
        .wbRd     (wbRd),
        .wbData   (wbData),
        .idEx     (idEx),
        .stall    (stall)
    );

    executeStage executeStage_inst (
        .clock    (clock),
        .reset    (reset),
        .idEx     (idEx),
        .exMemFb  (exMem),
        .wbWrite  (wbWrite),
        .wbRd     (wbRd),
        .wbData   (wbData),
        .exMem    (exMem),
        .redirect (redirect),
        .target   (target)
    );

    ////////////////////////////////////////
    // output side
    ////////////////////////////////////////

    memoryStage #(
        .dmemWords (dmemWords)
    ) memoryStage_inst (
        .clock      (clock),
        .reset      (reset),
        .exMem      (exMem),
        .memWbFb    (memWb),
        .memWb      (memWb),
        .wbWrite    (wbWrite),
        .wbRd       (wbRd),
        .wbData     (wbData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

endmodule

`default_nettype wire

// ==== dv/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 4
) (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #(periodNs / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clock);
        #1;
        reset = 1'b0; // released just after an edge
    end

endmodule

`default_nettype wire

// ==== dv/pipeMonitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeMonitor (
    input  wire logic        clock,
    input  wire logic        reset,
    input  wire logic        storeValid,
    input  wire logic [31:0] storeAddr,
    input  wire logic [31:0] storeData,
    output int               seenCount,
    output int               passedTests,
    output int               failedTests,
    output int               errorCount
);

    string             testName;
    int                expCount;
    logic [3:0][31:0]  expAddr;
    logic [3:0][31:0]  expData;
    int                testErrors;

    initial begin
        testName    = "none";
        expCount    = 0;
        expAddr     = '0;
        expData     = '0;
        testErrors  = 0;
        seenCount   = 0;
        passedTests = 0;
        failedTests = 0;
        errorCount  = 0;
    end

    task automatic beginTest(
        input string            name,
        input int               count,
        input logic [3:0][31:0] addrs,
        input logic [3:0][31:0] datas
    );
        testName   = name;
        expCount   = count;
        expAddr    = addrs;
        expData    = datas;
        seenCount  = 0;
        testErrors = 0;
    endtask

    ////////////////////////////////////////
    // store port
    ////////////////////////////////////////

    always @(posedge clock) begin
        if (!reset && storeValid === 1'b1) begin
            if (seenCount < expCount) begin
                if (storeAddr !== expAddr[seenCount]) begin
                    $display("[ERROR] %s store %0d: storeAddr got %h, expected %h",
                             testName, seenCount, storeAddr, expAddr[seenCount]);
                    testErrors++;
                end
                if (storeData !== expData[seenCount]) begin
                    $display("[ERROR] %s store %0d: storeData got %h, expected %h",
                             testName, seenCount, storeData, expData[seenCount]);
                    testErrors++;
                end
            end else begin
                $display("%s: unexpected extra store to address %h with data %h",
                         testName, storeAddr, storeData);
                testErrors++;
            end
            seenCount++;
        end
    end

    task automatic endTest();
        if (seenCount < expCount) begin
            $display("%s: %0d of %0d expected stores never appeared",
                     testName, expCount - seenCount, expCount);
            testErrors++;
        end
        errorCount += testErrors;
        if (testErrors == 0) begin
            passedTests++;
            $display("PASS  %s (%0d stores)", testName, seenCount);
        end else begin
            failedTests++;
            $display("FAIL  %s (%0d errors)", testName, testErrors);
        end
    endtask

endmodule

`default_nettype wire

// ==== dv/pipeTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipeTb;

    localparam int imemWords   = 64;
    localparam int dmemWords   = 64;
    localparam int numTests    = 5;
    localparam int maxWords    = 16;
    localparam int resetCycles = 4;
    localparam int waitLimit   = 200;
    localparam int tailCycles  = 20;

    localparam logic [6:0]  opImm    = 7'b0010011;
    localparam logic [6:0]  opLoad   = 7'b0000011;
    localparam logic [31:0] loopWord = 32'h0000_0063; // beq x0, x0, 0

    logic        clock;
    logic        powerReset;
    logic        testReset;
    logic        reset;
    logic        run;
    logic        progWrite;
    logic [5:0]  progAddr;
    logic [31:0] progData;
    logic        storeValid;
    logic [31:0] storeAddr;
    logic [31:0] storeData;
    int          seenCount;
    int          passedTests;
    int          failedTests;
    int          errorCount;
    int          timeouts;

    // test table
    string            testName  [numTests];
    logic             runEnable [numTests];
    logic [31:0]      progWords [numTests][maxWords];
    int               expCount  [numTests];
    logic [3:0][31:0] expAddr   [numTests];
    logic [3:0][31:0] expData   [numTests];

    assign reset = powerReset | testReset;

    clockGen #(
        .periodNs    (20),
        .resetCycles (resetCycles)
    ) clockGen_inst (
        .clock (clock),
        .reset (powerReset)
    );

    pipeTop #(
        .imemWords (imemWords),
        .dmemWords (dmemWords)
    ) pipeTop_inst (
        .clock      (clock),
        .reset      (reset),
        .run        (run),
        .progWrite  (progWrite),
        .progAddr   (progAddr),
        .progData   (progData),
        .storeValid (storeValid),
        .storeAddr  (storeAddr),
        .storeData  (storeData)
    );

    pipeMonitor storeMonitor (
        .clock       (clock),
        .reset       (reset),
        .storeValid  (storeValid),
        .storeAddr   (storeAddr),
        .storeData   (storeData),
        .seenCount   (seenCount),
        .passedTests (passedTests),
        .failedTests (failedTests),
        .errorCount  (errorCount)
    );

    ////////////////////////////////////////
    // instruction encoding
    ////////////////////////////////////////

    function automatic logic [31:0] regRegWord(input logic sub, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] immWord(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd,
                                            input logic [6:0] opcode);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    function automatic logic [31:0] storeWord(input logic [11:0] imm, input logic [4:0] rs2,
                                              input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branchWord(input logic [12:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic buildTable();
        int t;
        int i;
        for (t = 0; t < numTests; t++) begin
            for (i = 0; i < maxWords; i++) begin
                progWords[t][i] = loopWord; // program ends in a self loop
            end
            expAddr[t]   = '0;
            expData[t]   = '0;
            runEnable[t] = 1'b1;
        end
        // stores are present but run never rises
        testName[0]     = "idle with run low";
        runEnable[0]    = 1'b0;
        progWords[0][0] = storeWord(12'd0, 5'd0, 5'd0);
        progWords[0][1] = storeWord(12'd4, 5'd0, 5'd0);
        expCount[0]     = 0;

        testName[1]     = "forwarding chain";
        progWords[1][0] = immWord(12'h035, 5'd0, 3'b000, 5'd1, opImm); // addi x1, x0, 0x35
        progWords[1][1] = immWord(12'h00c, 5'd1, 3'b000, 5'd2, opImm); // addi x2, x1, 12
        progWords[1][2] = regRegWord(1'b0, 5'd2, 5'd1, 3'b000, 5'd3);  // add x3, x1, x2
        progWords[1][3] = storeWord(12'd0, 5'd3, 5'd0);
        progWords[1][4] = regRegWord(1'b1, 5'd1, 5'd3, 3'b000, 5'd4);  // sub x4, x3, x1
        progWords[1][5] = storeWord(12'd4, 5'd4, 5'd0);
        progWords[1][6] = regRegWord(1'b0, 5'd1, 5'd3, 3'b111, 5'd5);  // and x5, x3, x1
        progWords[1][7] = storeWord(12'd8, 5'd5, 5'd0);
        progWords[1][8] = regRegWord(1'b0, 5'd2, 5'd5, 3'b110, 5'd6);  // or x6, x5, x2
        progWords[1][9] = storeWord(12'd12, 5'd6, 5'd0);
        expCount[1]     = 4;
        expAddr[1]      = {32'd12, 32'd8, 32'd4, 32'd0};
        expData[1]      = {32'h75, 32'h34, 32'h41, 32'h76};

        testName[2]     = "load use and store data";
        progWords[2][0] = immWord(12'h123, 5'd0, 3'b000, 5'd7, opImm);   // addi x7, x0, 0x123
        progWords[2][1] = immWord(12'h045, 5'd0, 3'b000, 5'd8, opImm);   // addi x8, x0, 0x45
        progWords[2][2] = storeWord(12'd16, 5'd7, 5'd0);
        progWords[2][3] = immWord(12'd16, 5'd0, 3'b010, 5'd9, opLoad);   // lw x9, 16(x0)
        progWords[2][4] = regRegWord(1'b0, 5'd8, 5'd9, 3'b000, 5'd10);   // add x10, x9, x8
        progWords[2][5] = storeWord(12'd20, 5'd10, 5'd0);
        progWords[2][6] = immWord(12'd20, 5'd0, 3'b010, 5'd11, opLoad);  // lw x11, 20(x0)
        progWords[2][7] = storeWord(12'd24, 5'd11, 5'd0);                // data from writeback
        expCount[2]     = 3;
        expAddr[2]      = {32'd0, 32'd24, 32'd20, 32'd16};
        expData[2]      = {32'h0, 32'h168, 32'h168, 32'h123};

        testName[3]     = "branch flush";
        progWords[3][0] = immWord(12'd3, 5'd0, 3'b000, 5'd1, opImm);
        progWords[3][1] = immWord(12'd3, 5'd0, 3'b000, 5'd2, opImm);
        progWords[3][2] = branchWord(13'd12, 5'd2, 5'd1, 3'b000); // taken beq to word 5
        progWords[3][3] = storeWord(12'd32, 5'd1, 5'd0);
        progWords[3][4] = storeWord(12'd36, 5'd2, 5'd0);
        progWords[3][5] = immWord(12'd9, 5'd0, 3'b000, 5'd3, opImm);     // addi x3, x0, 9
        progWords[3][6] = branchWord(13'd8, 5'd2, 5'd1, 3'b001);  // bne not taken
        progWords[3][7] = storeWord(12'd40, 5'd3, 5'd0);
        expCount[3]     = 1;
        expAddr[3]      = {32'd0, 32'd0, 32'd0, 32'd40};
        expData[3]      = {32'h0, 32'h0, 32'h0, 32'h9};

        testName[4]     = "x0 stays zero";
        progWords[4][0] = immWord(12'h021, 5'd0, 3'b000, 5'd1, opImm);  // addi x1, x0, 0x21
        progWords[4][1] = immWord(12'h055, 5'd1, 3'b000, 5'd0, opImm);  // addi x0, x1, 0x55
        progWords[4][2] = storeWord(12'd44, 5'd0, 5'd0);
        progWords[4][3] = regRegWord(1'b0, 5'd1, 5'd1, 3'b000, 5'd0);   // add x0, x1, x1
        progWords[4][4] = storeWord(12'd48, 5'd0, 5'd0);
        expCount[4]     = 2;
        expAddr[4]      = {32'd0, 32'd0, 32'd48, 32'd44};
        expData[4]      = '0;
    endtask

    ////////////////////////////////////////
    // test loop
    ////////////////////////////////////////

    task automatic nextCycle();
        @(posedge clock);
        #1;
    endtask

    task automatic runTest(input int t);
        int i;
        int waited;
        run       = 1'b0;
        testReset = 1'b1;
        repeat (resetCycles) nextCycle();
        testReset = 1'b0;
        storeMonitor.beginTest(testName[t], expCount[t], expAddr[t], expData[t]);
        for (i = 0; i < maxWords; i++) begin
            progWrite = 1'b1;
            progAddr  = i[5:0];
            progData  = progWords[t][i];
            nextCycle();
        end
        progWrite = 1'b0;
        run       = runEnable[t];
        waited    = 0;
        while (seenCount < expCount[t] && waited < waitLimit) begin
            nextCycle();
            waited++;
        end
        if (seenCount < expCount[t]) begin
            $display("%s: timed out after %0d cycles waiting for stores", testName[t], waited);
            timeouts++;
        end
        repeat (tailCycles) nextCycle(); // room for stray stores
        run = 1'b0;
        storeMonitor.endTest();
    endtask

    initial begin
        int t;
        int waited;
        testReset = 1'b0;
        run       = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        timeouts  = 0;
        buildTable();
        waited = 0;
        while (powerReset !== 1'b0 && waited < 20) begin
            nextCycle();
            waited++;
        end
        if (powerReset === 1'b0) begin
            for (t = 0; t < numTests; t++) begin
                runTest(t);
            end
        end else begin
            $display("power-on reset was never released");
            timeouts++;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d, timeouts %0d",
                 passedTests + failedTests, passedTests, failedTests, errorCount, timeouts);
        if (failedTests == 0 && errorCount == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
